// ==== Makefile ====
# Verilator flow for the writeback stage

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_writeback_unit
RTL_TOP   ?= writeback_unit
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
wb_cfg_pkg.sv
wb_src_pkg.sv
wb_pending_table.sv
wb_arbiter.sv
wb_port_mux.sv
writeback_unit.sv
tb_writeback_unit.sv

// ==== tb_writeback_unit.sv ====
// directed and random checks of the writeback stage; requests never target register 0
`default_nettype none
`timescale 1ns/100ps

module tb_writeback_unit;

    import wb_cfg_pkg::*;
    import wb_src_pkg::*;

    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int CHECK_DLY   = 38;
    localparam int WAIT_LIMIT  = 20;
    localparam int RAND_ROUNDS = 40;

    logic       clk;
    logic       rst_n;
    logic       flush;
    src_vec_t   src_we;
    reg_data_t  src_data  [NUM_SRC];
    reg_addr_t  src_addr  [NUM_SRC];
    timestamp_t src_ts    [NUM_SRC];
    commit_id_t src_cid   [NUM_SRC];
    src_vec_t   src_ready;
    reg_addr_t  issue_rd  [2];
    timestamp_t issue_ts  [2];
    logic       issue_ready;
    logic [1:0] reg_we;
    reg_addr_t  reg_addr  [2];
    reg_data_t  reg_data  [2];
    logic [1:0] commit_valid;
    commit_id_t commit_id [2];

    // model of the pending table contents
    logic [TABLE_DEPTH-1:0] mdl_valid;
    reg_addr_t              mdl_addr [TABLE_DEPTH];
    timestamp_t             mdl_ts   [TABLE_DEPTH];

    int   err_count;
    int   test_count;
    int   test_fail;
    int   test_err0;
    logic timed_out;
    int   grant_cycle [NUM_SRC];

    writeback_unit i_writeback_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush),
        .src_we_i       (src_we),
        .src_data_i     (src_data),
        .src_addr_i     (src_addr),
        .src_ts_i       (src_ts),
        .src_cid_i      (src_cid),
        .src_ready_o    (src_ready),
        .issue_rd_i     (issue_rd),
        .issue_ts_i     (issue_ts),
        .issue_ready_o  (issue_ready),
        .reg_we_o       (reg_we),
        .reg_addr_o     (reg_addr),
        .reg_data_o     (reg_data),
        .commit_valid_o (commit_valid),
        .commit_id_o    (commit_id)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ========================================================================
    // reference model and checker
    // ========================================================================

    // [1:0] and [3:2] hold the two channel sources and [5:4] their valids
    function automatic logic [5:0] predict_grants(
        input src_vec_t               we,
        input reg_addr_t              addr [NUM_SRC],
        input timestamp_t             ts   [NUM_SRC],
        input logic [TABLE_DEPTH-1:0] mv,
        input reg_addr_t              ma   [TABLE_DEPTH],
        input timestamp_t             mt   [TABLE_DEPTH]
    );
        src_vec_t    elig;
        logic [5:0]  r;
        int          picked;
        r      = '0;
        picked = 0;
        for (int s = 0; s < NUM_SRC; s++) begin
            elig[s] = we[s];
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                if (mv[i] && ma[i] == addr[s] && mt[i] < ts[s]) elig[s] = 1'b0;
            end
            for (int t = 0; t < NUM_SRC; t++) begin
                if (t != s && we[t] && addr[t] == addr[s] && ts[t] < ts[s]) elig[s] = 1'b0;
            end
        end
        // highest index first
        for (int s = NUM_SRC - 1; s >= 0; s--) begin
            if (elig[s]) begin
                if (picked == 0) begin
                    r[1:0] = 2'(s);
                    r[4]   = 1'b1;
                end else if (picked == 1) begin
                    r[3:2] = 2'(s);
                    r[5]   = 1'b1;
                end
                picked++;
            end
        end
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    initial begin : output_check
        logic [5:0] g;
        logic [1:0] v;
        src_idx_t   gs [2];
        src_vec_t   exp_ready;
        logic       placed;
        forever begin
            @(posedge clk);
            #CHECK_DLY;
            if (!rst_n) begin
                mdl_valid = '0;
            end else begin
                g     = predict_grants(src_we, src_addr, src_ts, mdl_valid, mdl_addr, mdl_ts);
                v     = g[5:4];
                gs[0] = g[1:0];
                gs[1] = g[3:2];
                check_eq("issue_ready_o", 32'(issue_ready),
                         32'($countones(mdl_valid) <= TABLE_DEPTH - 2));
                if (flush) begin
                    check_eq("reg_we_o", 32'(reg_we), 32'd0);
                    check_eq("commit_valid_o", 32'(commit_valid), 32'd0);
                    check_eq("src_ready_o", 32'(src_ready), 32'd0);
                    mdl_valid = '0;
                end else begin
                    exp_ready = '0;
                    for (int c = 0; c < 2; c++) begin
                        if (v[c]) exp_ready[gs[c]] = 1'b1;
                        check_eq($sformatf("reg_addr_o[%0d]", c), 32'(reg_addr[c]),
                                 v[c] ? 32'(src_addr[gs[c]]) : 32'd0);
                        check_eq($sformatf("reg_data_o[%0d]", c), reg_data[c],
                                 v[c] ? src_data[gs[c]] : 32'd0);
                        check_eq($sformatf("commit_id_o[%0d]", c), 32'(commit_id[c]),
                                 v[c] ? 32'(src_cid[gs[c]]) : 32'd0);
                    end
                    check_eq("reg_we_o", 32'(reg_we), 32'(v));
                    check_eq("commit_valid_o", 32'(commit_valid), 32'(v));
                    check_eq("src_ready_o", 32'(src_ready), 32'(exp_ready));
                    // retire what the edge writes back, then take the issue pair
                    for (int c = 0; c < 2; c++) begin
                        for (int i = 0; i < TABLE_DEPTH; i++) begin
                            if (v[c] && mdl_valid[i] && mdl_addr[i] == src_addr[gs[c]] &&
                                mdl_ts[i] == src_ts[gs[c]]) mdl_valid[i] = 1'b0;
                        end
                    end
                    for (int k = 0; k < 2; k++) begin
                        placed = 1'b0;
                        for (int i = 0; i < TABLE_DEPTH; i++) begin
                            if (issue_rd[k] != '0 && !placed && !mdl_valid[i]) begin
                                mdl_valid[i] = 1'b1;
                                mdl_addr[i]  = issue_rd[k];
                                mdl_ts[i]    = issue_ts[k];
                                placed       = 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    // ========================================================================
    // stimulus helpers
    // ========================================================================

    task automatic set_req(input src_idx_t s, input reg_addr_t a, input timestamp_t t,
                           input commit_id_t c, input reg_data_t d);
        src_we[s]   = 1'b1;
        src_addr[s] = a;
        src_ts[s]   = t;
        src_cid[s]  = c;
        src_data[s] = d;
    endtask

    task automatic issue_pair(input reg_addr_t rd0, input timestamp_t ts0,
                              input reg_addr_t rd1, input timestamp_t ts1);
        check_eq("issue_ready_o", 32'(issue_ready), 32'd1);
        issue_rd[0] = rd0;
        issue_ts[0] = ts0;
        issue_rd[1] = rd1;
        issue_ts[1] = ts1;
        @(posedge clk);
        #DRIVE_DLY;
        issue_rd[0] = '0;
        issue_rd[1] = '0;
    endtask

    // each source drops its request after the edge where it saw ready
    task automatic hold_until_granted(input src_vec_t mask);
        src_vec_t left;
        src_vec_t seen;
        int       waited;
        left   = mask;
        waited = 0;
        for (int s = 0; s < NUM_SRC; s++) grant_cycle[s] = -1;
        while (left != '0 && waited < WAIT_LIMIT && !timed_out) begin
            @(negedge clk);
            seen = src_ready & left;
            @(posedge clk);
            #DRIVE_DLY;
            src_we = src_we & ~seen;
            for (int s = 0; s < NUM_SRC; s++) begin
                if (seen[s]) grant_cycle[s] = waited;
            end
            left = left & ~seen;
            waited++;
        end
        if (left != '0) begin
            $display("Timeout: requests 0x%0h never saw ready within %0d cycles",
                     left, WAIT_LIMIT);
            timed_out = 1'b1;
            src_we    = src_we & ~left;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_err0 && !timed_out) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_fail++;
            $display("test %0d %s: FAILED", test_count, name);
        end
        test_err0 = err_count;
    endtask

    // ========================================================================
    // tests
    // ========================================================================

    // ready seen mid-cycle means the write completes at the coming edge
    task automatic test_single();
        set_req(SRC_ALU, 5'd3, 32'd1, 3'd2, 32'hdead_0001);
        @(negedge clk);
        check_eq("reg_we_o", 32'(reg_we), 32'd1);
        check_eq("reg_addr_o[0]", 32'(reg_addr[0]), 32'd3);
        check_eq("reg_data_o[0]", reg_data[0], 32'hdead_0001);
        check_eq("commit_id_o[0]", 32'(commit_id[0]), 32'd2);
        check_eq("src_ready_o", 32'(src_ready), 32'h1);
        @(posedge clk);
        #DRIVE_DLY;
        src_we[SRC_ALU] = 1'b0;
    endtask

    task automatic test_all_four();
        set_req(SRC_ALU, 5'd1, 32'd10, 3'd0, 32'h1111_0000);
        set_req(SRC_MUL, 5'd2, 32'd11, 3'd1, 32'h2222_0000);
        set_req(SRC_DIV, 5'd3, 32'd12, 3'd2, 32'h3333_0000);
        set_req(SRC_LSU, 5'd4, 32'd13, 3'd3, 32'h4444_0000);
        hold_until_granted(4'b1111);
        check_eq("src_ready_o[3] cycle", 32'(grant_cycle[3]), 32'd0);
        check_eq("src_ready_o[2] cycle", 32'(grant_cycle[2]), 32'd0);
        check_eq("src_ready_o[1] cycle", 32'(grant_cycle[1]), 32'd1);
        check_eq("src_ready_o[0] cycle", 32'(grant_cycle[0]), 32'd1);
    endtask

    task automatic test_ordering();
        issue_pair(5'd7, 32'd5, 5'd7, 32'd9);
        set_req(SRC_MUL, 5'd7, 32'd9, 3'd4, 32'h0000_0009);
        for (int n = 0; n < 3; n++) begin
            @(negedge clk);
            check_eq("src_ready_o[1]", 32'(src_ready[SRC_MUL]), 32'd0);
            @(posedge clk);
            #DRIVE_DLY;
        end
        set_req(SRC_ALU, 5'd7, 32'd5, 3'd5, 32'h0000_0005);
        hold_until_granted(4'b0011);
        check_eq("src_ready_o[0] cycle", 32'(grant_cycle[0]), 32'd0);
        check_eq("src_ready_o[1] cycle", 32'(grant_cycle[1]), 32'd1);
    endtask

    // small address and timestamp ranges force collisions and ties
    task automatic test_random();
        src_vec_t we;
        for (int r = 0; r < RAND_ROUNDS && !timed_out; r++) begin
            we = src_vec_t'($urandom_range(1, 15));
            for (int s = 0; s < NUM_SRC; s++) begin
                if (we[s]) begin
                    set_req(src_idx_t'(s), reg_addr_t'($urandom_range(1, 3)),
                            timestamp_t'($urandom_range(0, 3)),
                            commit_id_t'($urandom_range(0, 7)), $urandom);
                end
            end
            hold_until_granted(we);
        end
    endtask

    task automatic test_flush();
        issue_pair(5'd9, 32'd20, 5'd0, 32'd0);
        set_req(SRC_DIV, 5'd9, 32'd30, 3'd6, 32'hd1d1_0030);
        @(negedge clk);
        check_eq("src_ready_o[2]", 32'(src_ready[SRC_DIV]), 32'd0);
        @(posedge clk);
        #DRIVE_DLY;
        flush = 1'b1;
        set_req(SRC_ALU, 5'd4, 32'd40, 3'd7, 32'ha1a1_0040);
        @(negedge clk);
        check_eq("reg_we_o", 32'(reg_we), 32'd0);
        check_eq("commit_valid_o", 32'(commit_valid), 32'd0);
        check_eq("src_ready_o", 32'(src_ready), 32'd0);
        @(posedge clk);
        #DRIVE_DLY;
        flush = 1'b0;
        @(negedge clk);
        check_eq("src_ready_o", 32'(src_ready), 32'h5);
        @(posedge clk);
        #DRIVE_DLY;
        src_we = '0;
    endtask

    initial begin : main_seq
        void'($urandom(32'hc3fa5d0a));
        err_count  = 0;
        test_count = 0;
        test_fail  = 0;
        test_err0  = 0;
        timed_out  = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        src_we     = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            src_data[s] = '0;
            src_addr[s] = 5'd1;
            src_ts[s]   = '0;
            src_cid[s]  = '0;
        end
        for (int k = 0; k < 2; k++) begin
            issue_rd[k] = '0;
            issue_ts[k] = '0;
        end
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        @(negedge clk);
        check_eq("issue_ready_o", 32'(issue_ready), 32'd1);
        check_eq("reg_we_o", 32'(reg_we), 32'd0);
        check_eq("commit_valid_o", 32'(commit_valid), 32'd0);
        check_eq("src_ready_o", 32'(src_ready), 32'd0);
        @(posedge clk);
        #DRIVE_DLY;
        end_test("reset state");
        if (!timed_out) test_single();
        end_test("single alu write");
        if (!timed_out) test_all_four();
        end_test("four source priority");
        if (!timed_out) test_ordering();
        end_test("older write first");
        if (!timed_out) test_random();
        end_test("random rounds");
        if (!timed_out) test_flush();
        end_test("flush");

        $display("tests %0d, failed %0d, check errors %0d", test_count, test_fail, err_count);
        if (err_count == 0 && test_fail == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== wb_arbiter.sv ====
// purely combinational; requests to address 0 are assumed never to be made
`default_nettype none
`timescale 1ns/100ps

module wb_arbiter (
    input  wire                           flush_i,
    input  wire wb_src_pkg::src_vec_t     req_we_i,
    input  wire wb_cfg_pkg::reg_addr_t    req_addr_i      [wb_src_pkg::NUM_SRC],
    input  wire wb_cfg_pkg::timestamp_t   req_ts_i        [wb_src_pkg::NUM_SRC],
    input  wire wb_src_pkg::src_vec_t     older_pending_i,

    output logic [1:0]                    grant_valid_o,
    output wb_src_pkg::src_idx_t          grant_src_o     [2],
    output wb_src_pkg::src_vec_t          src_ready_o
);

    import wb_src_pkg::*;

    src_vec_t same_blk;
    src_vec_t eligible;

    // =========================================================================
    // same-cycle ordering
    // =========================================================================

    // an older competitor to the same register holds this one back
    always_comb begin : same_cycle_order
        same_blk = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            for (int t = 0; t < NUM_SRC; t++) begin
                if (t != s && req_we_i[t] &&
                    req_addr_i[t] == req_addr_i[s] && req_ts_i[t] < req_ts_i[s]) begin
                    same_blk[s] = 1'b1;
                end
            end
        end
    end

    assign eligible = req_we_i & ~older_pending_i & ~same_blk;

    // =========================================================================
    // two-channel grant
    // =========================================================================

    // each new winner walking up in priority pushes the previous one to channel 1
    always_comb begin : grant_pick
        grant_valid_o  = 2'b00;
        grant_src_o[0] = SRC_ALU;
        grant_src_o[1] = SRC_ALU;
        for (int s = int'(SRC_ALU); s <= int'(SRC_LSU); s++) begin
            if (eligible[s]) begin
                grant_valid_o[1] = grant_valid_o[0];
                grant_src_o[1]   = grant_src_o[0];
                grant_valid_o[0] = 1'b1;
                grant_src_o[0]   = src_idx_t'(s);
            end
        end
    end

    always_comb begin : ready_gen
        src_ready_o = '0;
        for (int c = 0; c < 2; c++) begin
            if (grant_valid_o[c]) begin
                src_ready_o[grant_src_o[c]] = 1'b1;
            end
        end
        // nothing completes under flush
        if (flush_i) begin
            src_ready_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== wb_cfg_pkg.sv ====
// timestamps compare as unsigned, so the issue counter must not wrap while a write is pending
`default_nettype none

package wb_cfg_pkg;

    // =========================================================================
    // datapath widths
    // =========================================================================

    localparam int DATA_W = 32;
    localparam int ADDR_W = 5;
    // smaller value is the older instruction
    localparam int TS_W   = 32;
    localparam int CID_W  = 3;

    // =========================================================================
    // pending write table
    // =========================================================================

    localparam int TABLE_DEPTH = 8;
    // one extra code so a full table can be counted
    localparam int TABLE_CNT_W = $clog2(TABLE_DEPTH + 1);

    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] reg_data_t;
    typedef logic [TS_W-1:0]   timestamp_t;
    typedef logic [CID_W-1:0]  commit_id_t;

endpackage

`default_nettype wire

// ==== wb_pending_table.sv ====
// issuing with issue_ready_o low is illegal; entries are visible one cycle after the issue edge
`default_nettype none
`timescale 1ns/100ps

module wb_pending_table (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           flush_i,

    // zero rd on the issue side means no destination
    input  wire wb_cfg_pkg::reg_addr_t    issue_rd_i     [2],
    input  wire wb_cfg_pkg::timestamp_t   issue_ts_i     [2],

    // granted writes from the two channels
    input  wire [1:0]                     retire_valid_i,
    input  wire wb_cfg_pkg::reg_addr_t    retire_addr_i  [2],
    input  wire wb_cfg_pkg::timestamp_t   retire_ts_i    [2],

    // lookup for every source
    input  wire wb_cfg_pkg::reg_addr_t    req_addr_i     [wb_src_pkg::NUM_SRC],
    input  wire wb_cfg_pkg::timestamp_t   req_ts_i       [wb_src_pkg::NUM_SRC],

    output wb_src_pkg::src_vec_t          older_pending_o,
    output logic                          issue_ready_o
);

    import wb_cfg_pkg::*;
    import wb_src_pkg::*;

    logic [TABLE_DEPTH-1:0] ent_valid;
    reg_addr_t              ent_addr [TABLE_DEPTH];
    timestamp_t             ent_ts   [TABLE_DEPTH];
    logic [TABLE_CNT_W-1:0] count_q;

    logic [1:0]             issue_en;
    logic [TABLE_DEPTH-1:0] free_a_oh;
    logic [TABLE_DEPTH-1:0] free_b_oh;
    logic [TABLE_DEPTH-1:0] alloc0_oh;
    logic [TABLE_DEPTH-1:0] alloc1_oh;
    logic [TABLE_DEPTH-1:0] clear_oh;
    logic [TABLE_CNT_W-1:0] n_alloc;
    logic [TABLE_CNT_W-1:0] n_clear;

    // =========================================================================
    // allocation
    // =========================================================================

    assign issue_en[0] = !flush_i && (issue_rd_i[0] != '0);
    assign issue_en[1] = !flush_i && (issue_rd_i[1] != '0);

    // lowest and second lowest free slot
    always_comb begin : slot_pick
        logic first_done;
        logic second_done;
        first_done  = 1'b0;
        second_done = 1'b0;
        free_a_oh   = '0;
        free_b_oh   = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (!ent_valid[i]) begin
                if (!first_done) begin
                    free_a_oh[i] = 1'b1;
                    first_done   = 1'b1;
                end else if (!second_done) begin
                    free_b_oh[i] = 1'b1;
                    second_done  = 1'b1;
                end
            end
        end
    end

    // port 1 slides down to the lowest slot when port 0 has no rd
    assign alloc0_oh = issue_en[0] ? free_a_oh : '0;
    assign alloc1_oh = !issue_en[1] ? '0 : (issue_en[0] ? free_b_oh : free_a_oh);

    assign n_alloc = TABLE_CNT_W'(issue_en[0]) + TABLE_CNT_W'(issue_en[1]);

    // =========================================================================
    // retirement
    // =========================================================================

    // an entry goes when a channel writes its exact address and timestamp
    always_comb begin : retire_match
        clear_oh = '0;
        n_clear  = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            for (int k = 0; k < 2; k++) begin
                if (ent_valid[i] && retire_valid_i[k] &&
                    ent_addr[i] == retire_addr_i[k] && ent_ts[i] == retire_ts_i[k]) begin
                    clear_oh[i] = 1'b1;
                end
            end
            n_clear = n_clear + TABLE_CNT_W'(clear_oh[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
            count_q   <= '0;
        end else if (flush_i) begin
            ent_valid <= '0;
            count_q   <= '0;
        end else begin
            ent_valid <= (ent_valid & ~clear_oh) | alloc0_oh | alloc1_oh;
            count_q   <= count_q + n_alloc - n_clear;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (alloc0_oh[i]) begin
                ent_addr[i] <= issue_rd_i[0];
                ent_ts[i]   <= issue_ts_i[0];
            end else if (alloc1_oh[i]) begin
                ent_addr[i] <= issue_rd_i[1];
                ent_ts[i]   <= issue_ts_i[1];
            end
        end
    end

    // room for a full issue pair
    assign issue_ready_o = (count_q <= TABLE_CNT_W'(TABLE_DEPTH - 2));

    // =========================================================================
    // older write lookup
    // =========================================================================

    // equal timestamp is the request's own entry
    always_comb begin : older_check
        older_pending_o = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                if (ent_valid[i] && ent_addr[i] == req_addr_i[s] && ent_ts[i] < req_ts_i[s]) begin
                    older_pending_o[s] = 1'b1;
                end
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= TABLE_CNT_W'(TABLE_DEPTH))
        else $error("pending table count 0x%0h above depth", count_q);

    // issue stage must respect back-pressure
    a_issue_room: assert property (@(posedge clk) disable iff (!rst_n)
        (|issue_en) |-> issue_ready_o)
        else $error("issue while table has fewer than two free entries");

endmodule

`default_nettype wire

// ==== wb_port_mux.sv ====
// one channel; retire_valid_o ignores flush, the table discards retires during flush itself
`default_nettype none
`timescale 1ns/100ps

module wb_port_mux (
    input  wire                           flush_i,
    input  wire                           grant_valid_i,
    input  wire wb_src_pkg::src_idx_t     grant_src_i,
    input  wire wb_cfg_pkg::reg_data_t    src_data_i [wb_src_pkg::NUM_SRC],
    input  wire wb_cfg_pkg::reg_addr_t    src_addr_i [wb_src_pkg::NUM_SRC],
    input  wire wb_cfg_pkg::timestamp_t   src_ts_i   [wb_src_pkg::NUM_SRC],
    input  wire wb_cfg_pkg::commit_id_t   src_cid_i  [wb_src_pkg::NUM_SRC],

    // register file port and commit report
    output logic                          reg_we_o,
    output wb_cfg_pkg::reg_addr_t         reg_addr_o,
    output wb_cfg_pkg::reg_data_t         reg_data_o,
    output logic                          commit_valid_o,
    output wb_cfg_pkg::commit_id_t        commit_id_o,

    // back to the pending table
    output logic                          retire_valid_o,
    output wb_cfg_pkg::reg_addr_t         retire_addr_o,
    output wb_cfg_pkg::timestamp_t        retire_ts_o
);

    import wb_cfg_pkg::*;

    reg_addr_t  sel_addr;
    timestamp_t sel_ts;

    // fields read as zero on an idle channel
    always_comb begin : field_select
        sel_addr    = '0;
        sel_ts      = '0;
        reg_data_o  = '0;
        commit_id_o = '0;
        if (grant_valid_i) begin
            sel_addr    = src_addr_i[grant_src_i];
            sel_ts      = src_ts_i[grant_src_i];
            reg_data_o  = src_data_i[grant_src_i];
            commit_id_o = src_cid_i[grant_src_i];
        end
    end

    assign reg_addr_o     = sel_addr;
    assign reg_we_o       = grant_valid_i && !flush_i;
    assign commit_valid_o = grant_valid_i && !flush_i;

    assign retire_valid_o = grant_valid_i;
    assign retire_addr_o  = sel_addr;
    assign retire_ts_o    = sel_ts;

endmodule

`default_nettype wire

// ==== wb_src_pkg.sv ====
// four single-lane sources; the index doubles as grant priority, so renumbering changes arbitration
`default_nettype none

package wb_src_pkg;

    // =========================================================================
    // writeback sources
    // =========================================================================

    localparam int NUM_SRC = 4;

    typedef logic [$clog2(NUM_SRC)-1:0] src_idx_t;
    typedef logic [NUM_SRC-1:0]         src_vec_t;

    // priority order follows the index
    // LSU beats DIV, DIV beats MUL, MUL beats ALU
    localparam src_idx_t SRC_ALU = 2'd0;
    localparam src_idx_t SRC_MUL = 2'd1;
    localparam src_idx_t SRC_DIV = 2'd2;
    localparam src_idx_t SRC_LSU = 2'd3;

endpackage

`default_nettype wire

// ==== writeback_unit.sv ====
// writeback is combinational; a granted request leaves in the cycle it is presented
`default_nettype none
`timescale 1ns/100ps

module writeback_unit (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           flush_i,

    // result sources indexed by source number
    input  wire wb_src_pkg::src_vec_t     src_we_i,
    input  wire wb_cfg_pkg::reg_data_t    src_data_i     [wb_src_pkg::NUM_SRC],
    input  wire wb_cfg_pkg::reg_addr_t    src_addr_i     [wb_src_pkg::NUM_SRC],
    input  wire wb_cfg_pkg::timestamp_t   src_ts_i       [wb_src_pkg::NUM_SRC],
    input  wire wb_cfg_pkg::commit_id_t   src_cid_i      [wb_src_pkg::NUM_SRC],
    output wire wb_src_pkg::src_vec_t     src_ready_o,

    // issue stage
    input  wire wb_cfg_pkg::reg_addr_t    issue_rd_i     [2],
    input  wire wb_cfg_pkg::timestamp_t   issue_ts_i     [2],
    output wire                           issue_ready_o,

    // register file write ports and commit reports
    output wire [1:0]                     reg_we_o,
    output wire wb_cfg_pkg::reg_addr_t    reg_addr_o     [2],
    output wire wb_cfg_pkg::reg_data_t    reg_data_o     [2],
    output wire [1:0]                     commit_valid_o,
    output wire wb_cfg_pkg::commit_id_t   commit_id_o    [2]
);

    wire wb_src_pkg::src_vec_t   older_pending;
    wire [1:0]                   grant_valid;
    wire wb_src_pkg::src_idx_t   grant_src    [2];
    wire [1:0]                   retire_valid;
    wire wb_cfg_pkg::reg_addr_t  retire_addr  [2];
    wire wb_cfg_pkg::timestamp_t retire_ts    [2];

    wb_pending_table i_pending_table (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .issue_rd_i      (issue_rd_i),
        .issue_ts_i      (issue_ts_i),
        .retire_valid_i  (retire_valid),
        .retire_addr_i   (retire_addr),
        .retire_ts_i     (retire_ts),
        .req_addr_i      (src_addr_i),
        .req_ts_i        (src_ts_i),
        .older_pending_o (older_pending),
        .issue_ready_o   (issue_ready_o)
    );

    wb_arbiter i_arbiter (
        .flush_i         (flush_i),
        .req_we_i        (src_we_i),
        .req_addr_i      (src_addr_i),
        .req_ts_i        (src_ts_i),
        .older_pending_i (older_pending),
        .grant_valid_o   (grant_valid),
        .grant_src_o     (grant_src),
        .src_ready_o     (src_ready_o)
    );

    // channel 0 carries the higher-priority grant
    for (genvar c = 0; c < 2; c++) begin : g_chan
        wb_port_mux i_port_mux (
            .flush_i        (flush_i),
            .grant_valid_i  (grant_valid[c]),
            .grant_src_i    (grant_src[c]),
            .src_data_i     (src_data_i),
            .src_addr_i     (src_addr_i),
            .src_ts_i       (src_ts_i),
            .src_cid_i      (src_cid_i),
            .reg_we_o       (reg_we_o[c]),
            .reg_addr_o     (reg_addr_o[c]),
            .reg_data_o     (reg_data_o[c]),
            .commit_valid_o (commit_valid_o[c]),
            .commit_id_o    (commit_id_o[c]),
            .retire_valid_o (retire_valid[c]),
            .retire_addr_o  (retire_addr[c]),
            .retire_ts_o    (retire_ts[c])
        );
    end

endmodule

`default_nettype wire
